// File: backend_top.sv
module backend_top #(
    parameter int ways = 2
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [$clog2(ways+1)-1:0]          dispatch_count,    // Zero unless dispatch_ready
    input  r10k_pkg::addr_t [ways-1:0]         dispatch_npc,
    input  r10k_pkg::arch_reg_idx_t [ways-1:0] dispatch_arch_dest,
    input  logic [ways-1:0]                    dispatch_has_dest,
    input  logic [ways-1:0]                    dispatch_halt,
    input  logic [ways-1:0]                    dispatch_illegal,
    output logic                               dispatch_ready,
    output r10k_pkg::phys_reg_idx_t [ways-1:0] dispatch_t_new,
    input  logic [ways-1:0]                    wb_valid,          // One strobe per writeback port
    input  r10k_pkg::phys_reg_idx_t [ways-1:0] wb_phys_reg,
    input  r10k_pkg::data_t [ways-1:0]         wb_data,
    output logic [ways-1:0]                    committed_valid,
    output r10k_pkg::addr_t [ways-1:0]         committed_npc,
    output r10k_pkg::arch_reg_idx_t [ways-1:0] committed_reg_idx,
    output r10k_pkg::data_t [ways-1:0]         committed_data,
    output logic [ways-1:0]                    committed_halt,
    output logic [ways-1:0]                    committed_illegal,
    output logic                               halted
);
    import r10k_pkg::*;

    rob_packet_t    [ways-1:0] dispatch_packets;
    phys_reg_idx_t  [ways-1:0] dispatch_t_old;
    commit_packet_t [ways-1:0] committed_insts;
    logic                      rob_space_ok;
    logic                      free_ok;

    retire_if #(.ways(ways)) retire_bus ();

    // Both the ROB and the free list must take a whole group
    assign dispatch_ready = rob_space_ok && free_ok;

    for (genvar g = 0; g < ways; g++) begin : g_slot
        assign dispatch_packets[g] = '{
            npc:       dispatch_npc[g],
            arch_dest: dispatch_arch_dest[g],
            has_dest:  dispatch_has_dest[g],
            t_new:     dispatch_t_new[g],
            t_old:     dispatch_t_old[g],
            halt:      dispatch_halt[g],
            illegal:   dispatch_illegal[g]
        };
        assign committed_valid[g]   = committed_insts[g].valid;
        assign committed_npc[g]     = committed_insts[g].npc;
        assign committed_reg_idx[g] = committed_insts[g].reg_idx;
        assign committed_data[g]    = committed_insts[g].data;
        assign committed_halt[g]    = committed_insts[g].halt;
        assign committed_illegal[g] = committed_insts[g].illegal;
    end

    rob #(.ways(ways)) rob0 (
        .clock            (clock),
        .reset            (reset),
        .dispatch_count   (dispatch_count),
        .dispatch_packets (dispatch_packets),
        .rob_space_ok     (rob_space_ok),
        .rob_port         (retire_bus.rob_side)
    );

    rename_table #(.ways(ways)) rename0 (
        .clock              (clock),
        .reset              (reset),
        .dispatch_count     (dispatch_count),
        .dispatch_arch_dest (dispatch_arch_dest),
        .dispatch_has_dest  (dispatch_has_dest),
        .dispatch_t_new     (dispatch_t_new),
        .dispatch_t_old     (dispatch_t_old),
        .free_ok            (free_ok),
        .wb_valid           (wb_valid),
        .wb_phys_reg        (wb_phys_reg),
        .rename_port        (retire_bus.rename_side)
    );

    phys_regfile #(.ways(ways)) regfile0 (
        .clock        (clock),
        .reset        (reset),
        .wb_valid     (wb_valid),
        .wb_phys_reg  (wb_phys_reg),
        .wb_data      (wb_data),
        .regfile_port (retire_bus.regfile_side)
    );

    retire #(.ways(ways)) retire0 (
        .clock           (clock),
        .reset           (reset),
        .retire_port     (retire_bus.retire_side),
        .committed_insts (committed_insts),
        .halted          (halted)
    );

endmodule

// File: commit_checker.sv
module commit_checker #(
    parameter int ways = 2
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               ready_expected,    // Driven high after a full drain
    input  logic [$clog2(ways+1)-1:0]          dispatch_count,
    input  r10k_pkg::addr_t [ways-1:0]         dispatch_npc,
    input  r10k_pkg::arch_reg_idx_t [ways-1:0] dispatch_arch_dest,
    input  logic [ways-1:0]                    dispatch_halt,
    input  logic [ways-1:0]                    dispatch_illegal,
    input  logic                               dispatch_ready,
    input  r10k_pkg::phys_reg_idx_t [ways-1:0] dispatch_t_new,
    input  logic [ways-1:0]                    wb_valid,
    input  r10k_pkg::phys_reg_idx_t [ways-1:0] wb_phys_reg,
    input  r10k_pkg::data_t [ways-1:0]         wb_data,
    input  logic [ways-1:0]                    committed_valid,
    input  r10k_pkg::addr_t [ways-1:0]         committed_npc,
    input  r10k_pkg::arch_reg_idx_t [ways-1:0] committed_reg_idx,
    input  r10k_pkg::data_t [ways-1:0]         committed_data,
    input  logic [ways-1:0]                    committed_halt,
    input  logic [ways-1:0]                    committed_illegal,
    input  logic                               halted,
    output int                                 error_count,
    output int                                 commit_count,
    output int                                 outstanding       // Dispatched but not yet committed
);
    import r10k_pkg::*;

    // What the checker remembers about one dispatched instruction
    typedef struct packed {
        addr_t         npc;
        arch_reg_idx_t arch_dest;
        logic          halt;
        logic          illegal;
        phys_reg_idx_t t_new;
    } inst_rec_t;

    inst_rec_t program_order [$];               // Oldest instruction at the front
    data_t     written_data [phys_reg_count];   // Last value written back to each register
    logic      written      [phys_reg_count];   // Cleared when the register is allocated again
    time       wb_time      [phys_reg_count];
    logic      halt_committed = 1'b0;
    int        errors  = 0;
    int        commits = 0;
    int        in_flight = 0;                   // Size of program_order after each edge

    assign error_count  = errors;
    assign commit_count = commits;
    assign outstanding  = in_flight;

    task automatic report_error(input string msg);
        errors++;
        $display("CHECK FAILED at time %0t: %s", $time, msg);
    endtask

    // Reference model of one commit, built from program order and the writeback history
    function automatic commit_packet_t predict_commit(input inst_rec_t rec);
        commit_packet_t exp_pkt;
        exp_pkt.npc     = rec.npc;
        exp_pkt.reg_idx = rec.arch_dest;      // Passed through even without a destination
        exp_pkt.data    = written_data[rec.t_new];
        exp_pkt.halt    = rec.halt;
        exp_pkt.illegal = rec.illegal;
        exp_pkt.valid   = 1'b1;
        return exp_pkt;
    endfunction

    task automatic compare_slot(input int slot);
        inst_rec_t      rec;
        commit_packet_t exp_pkt;
        if (halt_committed) begin
            report_error($sformatf("slot %0d committed npc %h after the halt",
                                   slot, committed_npc[slot]));
        end
        if (program_order.size() == 0) begin
            report_error($sformatf("slot %0d committed npc %h with nothing in flight",
                                   slot, committed_npc[slot]));
            return;
        end
        rec     = program_order.pop_front();
        exp_pkt = predict_commit(rec);
        commits++;
        // The writeback edge must lie strictly before the commit
        if (!written[rec.t_new] || wb_time[rec.t_new] >= $time) begin
            report_error($sformatf("npc %h committed before its writeback to p%0d",
                                   rec.npc, rec.t_new));
        end else if (committed_data[slot] !== exp_pkt.data) begin
            report_error($sformatf("slot %0d data %h, expected %h", slot,
                                   committed_data[slot], exp_pkt.data));
        end
        if (committed_npc[slot] !== exp_pkt.npc) begin
            report_error($sformatf("slot %0d npc %h, expected %h", slot,
                                   committed_npc[slot], exp_pkt.npc));
        end
        if (committed_reg_idx[slot] !== exp_pkt.reg_idx) begin
            report_error($sformatf("slot %0d reg_idx %0d, expected %0d", slot,
                                   committed_reg_idx[slot], exp_pkt.reg_idx));
        end
        if (committed_halt[slot] !== exp_pkt.halt || committed_illegal[slot] !== exp_pkt.illegal) begin
            report_error($sformatf("slot %0d halt/illegal %b%b, expected %b%b", slot,
                                   committed_halt[slot], committed_illegal[slot],
                                   exp_pkt.halt, exp_pkt.illegal));
        end
        if (rec.halt) begin
            halt_committed = 1'b1;  // Every later commit is an error from here on
        end
    endtask

    // Commits refer to older edges, so they are compared before this edge's dispatch and writeback
    always @(posedge clock) begin
        logic gap_seen;
        inst_rec_t rec;
        if (reset) begin
            program_order.delete();
            halt_committed = 1'b0;
        end else begin
            if (halted !== halt_committed) begin
                report_error($sformatf("halted is %b, expected %b", halted, halt_committed));
            end
            if (ready_expected && !dispatch_ready) begin
                report_error("dispatch_ready low after a full drain, registers were not recycled");
            end
            gap_seen = 1'b0;
            for (int i = 0; i < ways; i++) begin
                if (!committed_valid[i]) begin
                    gap_seen = 1'b1;
                end else begin
                    if (gap_seen) begin
                        report_error($sformatf("slot %0d valid after an empty slot", i));
                    end
                    compare_slot(i);
                end
            end
            for (int i = 0; i < int'(dispatch_count); i++) begin
                rec.npc       = dispatch_npc[i];
                rec.arch_dest = dispatch_arch_dest[i];
                rec.halt      = dispatch_halt[i];
                rec.illegal   = dispatch_illegal[i];
                rec.t_new     = dispatch_t_new[i];
                program_order.push_back(rec);
                written[dispatch_t_new[i]] = 1'b0;  // A fresh life for this register
            end
            for (int i = 0; i < ways; i++) begin
                if (wb_valid[i]) begin
                    written[wb_phys_reg[i]]      = 1'b1;
                    written_data[wb_phys_reg[i]] = wb_data[i];
                    wb_time[wb_phys_reg[i]]      = $time;
                end
            end
        end
        in_flight = program_order.size();
    end

endmodule

// File: list.f
r10k_pkg.sv
retire_if.sv
rob.sv
rename_table.sv
phys_regfile.sv
retire.sv
backend_top.sv
commit_checker.sv
tb_backend.sv

// File: phys_regfile.sv
module phys_regfile #(
    parameter int ways = 2
) (
    input  logic                               clock,
    input  logic                               reset,        // Clears every register
    input  logic [ways-1:0]                    wb_valid,
    input  r10k_pkg::phys_reg_idx_t [ways-1:0] wb_phys_reg,
    input  r10k_pkg::data_t [ways-1:0]         wb_data,
    retire_if.regfile_side                     regfile_port
);
    import r10k_pkg::*;

    data_t regs [phys_reg_count];

    always_comb begin
        for (int i = 0; i < ways; i++) begin
            regfile_port.retire_read_data[i] = regs[regfile_port.retire_phys_regs_reading[i]];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < phys_reg_count; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < ways; i++) begin
                if (wb_valid[i]) begin
                    regs[wb_phys_reg[i]] <= wb_data[i];
                end
            end
        end
    end

endmodule

// File: r10k_pkg.sv
package r10k_pkg;

    localparam int arch_reg_count = 32;  // Architectural registers visible to software
    localparam int phys_reg_count = 64;  // Physical registers behind the rename map
    localparam int rob_depth      = 16;  // Must stay a power of two, pointers wrap naturally

    typedef logic [4:0]  arch_reg_idx_t;
    typedef logic [5:0]  phys_reg_idx_t;
    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;

    // One in-flight instruction, written at dispatch and read back at retire
    typedef struct packed {
        addr_t         npc;
        arch_reg_idx_t arch_dest;
        logic          has_dest;   // Without a destination t_old is a copy of t_new
        phys_reg_idx_t t_new;      // Register that receives the result
        phys_reg_idx_t t_old;      // Previous mapping, freed when this entry retires
        logic          halt;
        logic          illegal;
    } rob_packet_t;

    // One committed instruction as seen outside the backend
    typedef struct packed {
        addr_t         npc;
        arch_reg_idx_t reg_idx;    // Architectural destination
        data_t         data;       // Value read from t_new
        logic          halt;
        logic          illegal;
        logic          valid;
    } commit_packet_t;

    // Once halted the retire stage commits nothing until the next reset
    typedef enum logic {
        retire_running,
        retire_halted
    } retire_state_t;

endpackage

// File: rename_table.sv
module rename_table #(
    parameter int ways = 2
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [$clog2(ways+1)-1:0]          dispatch_count,
    input  r10k_pkg::arch_reg_idx_t [ways-1:0] dispatch_arch_dest,
    input  logic [ways-1:0]                    dispatch_has_dest,
    output r10k_pkg::phys_reg_idx_t [ways-1:0] dispatch_t_new,   // Head of the free list onward
    output r10k_pkg::phys_reg_idx_t [ways-1:0] dispatch_t_old,
    output logic                               free_ok,          // A whole group can be renamed
    input  logic [ways-1:0]                    wb_valid,
    input  r10k_pkg::phys_reg_idx_t [ways-1:0] wb_phys_reg,
    retire_if.rename_side                      rename_port
);
    import r10k_pkg::*;

    localparam int fl_ptr_w = $clog2(phys_reg_count);
    localparam int fl_cnt_w = fl_ptr_w + 1;
    localparam int spare    = phys_reg_count - arch_reg_count;  // Free registers after reset

    phys_reg_idx_t         map_table [arch_reg_count];  // Architectural to physical mapping
    phys_reg_idx_t         map_next  [arch_reg_count];
    phys_reg_idx_t         free_fifo [phys_reg_count];
    logic [fl_ptr_w-1:0]   fl_head;
    logic [fl_ptr_w-1:0]   fl_tail;
    logic [fl_cnt_w-1:0]   fl_count;
    logic [phys_reg_count-1:0] complete;

    assign free_ok                   = fl_count >= fl_cnt_w'(ways);
    assign rename_port.complete_list = complete;

    // Renaming walks the group in order, so a later slot sees the mapping of an earlier one
    always_comb begin
        map_next = map_table;
        for (int i = 0; i < ways; i++) begin
            dispatch_t_new[i] = free_fifo[fl_head + fl_ptr_w'(i)];
            dispatch_t_old[i] = dispatch_t_new[i];  // No destination frees its own register
            if (i < dispatch_count && dispatch_has_dest[i]) begin
                dispatch_t_old[i] = map_next[dispatch_arch_dest[i]];
                map_next[dispatch_arch_dest[i]] = dispatch_t_new[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < arch_reg_count; r++) begin
                map_table[r] <= phys_reg_idx_t'(r);  // Identity mapping
            end
            for (int f = 0; f < spare; f++) begin
                free_fifo[f] <= phys_reg_idx_t'(arch_reg_count + f);
            end
            fl_head  <= '0;
            fl_tail  <= fl_ptr_w'(spare);
            fl_count <= fl_cnt_w'(spare);
            complete <= {{spare{1'b0}}, {arch_reg_count{1'b1}}};  // Mapped registers hold values
        end else begin
            map_table <= map_next;
            fl_head   <= fl_head + fl_ptr_w'(dispatch_count);
            fl_tail   <= fl_tail + fl_ptr_w'(rename_port.retire_count);
            fl_count  <= fl_count + fl_cnt_w'(rename_port.retire_count)
                         - fl_cnt_w'(dispatch_count);
            // Freed registers join the tail and reach the allocator one edge later
            for (int i = 0; i < ways; i++) begin
                if (i < rename_port.retire_count) begin
                    free_fifo[fl_tail + fl_ptr_w'(i)] <= rename_port.phys_regs_retiring[i];
                end
            end
            for (int i = 0; i < ways; i++) begin
                if (i < dispatch_count) begin
                    complete[dispatch_t_new[i]] <= 1'b0;  // Pending until written back
                end
            end
            // A register just allocated cannot be written back in the same cycle
            for (int i = 0; i < ways; i++) begin
                if (wb_valid[i]) begin
                    complete[wb_phys_reg[i]] <= 1'b1;
                end
            end
        end
    end

endmodule

// File: retire.sv
module retire #(
    parameter int ways = 2
) (
    input  logic                                clock,
    input  logic                                reset,
    retire_if.retire_side                       retire_port,
    output r10k_pkg::commit_packet_t [ways-1:0] committed_insts,
    output logic                                halted
);
    import r10k_pkg::*;

    localparam int count_w = $clog2(ways + 1);

    retire_state_t      state;
    retire_state_t      state_next;
    logic               stop;         // Set once a slot cannot retire, later slots follow
    logic [count_w-1:0] n_retire;

    assign halted = (state == retire_halted);

    always_comb begin
        stop                                 = (state == retire_halted);
        state_next                           = state;
        n_retire                             = '0;
        committed_insts                      = '0;
        retire_port.phys_regs_retiring       = '0;
        for (int i = 0; i < ways; i++) begin
            // Read t_new for every slot, only retiring slots use the data
            retire_port.retire_phys_regs_reading[i] = retire_port.rob_outputs[i].t_new;
            if (!stop && i < retire_port.rob_outputs_valid &&
                retire_port.complete_list[retire_port.rob_outputs[i].t_new]) begin
                committed_insts[i].npc     = retire_port.rob_outputs[i].npc;
                committed_insts[i].reg_idx = retire_port.rob_outputs[i].arch_dest;
                committed_insts[i].data    = retire_port.retire_read_data[i];
                committed_insts[i].halt    = retire_port.rob_outputs[i].halt;
                committed_insts[i].illegal = retire_port.rob_outputs[i].illegal;
                committed_insts[i].valid   = 1'b1;
                retire_port.phys_regs_retiring[i] = retire_port.rob_outputs[i].t_old;
                n_retire = n_retire + 1'b1;
                if (retire_port.rob_outputs[i].halt) begin
                    stop       = 1'b1;           // Nothing younger than a halt commits
                    state_next = retire_halted;
                end
            end else begin
                stop = 1'b1;                     // In-order retirement stops at the first gap
            end
        end
        retire_port.num_retiring = n_retire;     // Entries popped from the ROB
        retire_port.retire_count = n_retire;     // T_old registers returned to the free list
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= retire_running;
        end else begin
            state <= state_next;
        end
    end

endmodule

// File: retire_if.sv
interface retire_if #(
    parameter int ways = 2
);
    import r10k_pkg::*;

    localparam int count_w = $clog2(ways + 1);

    rob_packet_t   [ways-1:0]      rob_outputs;               // Oldest entries, slot 0 is the head
    logic          [count_w-1:0]   rob_outputs_valid;         // How many of those are occupied
    logic          [count_w-1:0]   num_retiring;              // Entries popped at the next edge
    logic          [phys_reg_count-1:0] complete_list;        // Written back since allocation
    phys_reg_idx_t [ways-1:0]      phys_regs_retiring;        // T_old registers, packed from slot 0
    logic          [count_w-1:0]   retire_count;              // Valid slots of phys_regs_retiring
    phys_reg_idx_t [ways-1:0]      retire_phys_regs_reading;  // Register file read addresses
    data_t         [ways-1:0]      retire_read_data;

    modport retire_side (
        input  rob_outputs, rob_outputs_valid, complete_list, retire_read_data,
        output num_retiring, phys_regs_retiring, retire_count, retire_phys_regs_reading
    );

    modport rob_side (output rob_outputs, rob_outputs_valid, input num_retiring);

    modport rename_side (output complete_list, input phys_regs_retiring, retire_count);

    modport regfile_side (input retire_phys_regs_reading, output retire_read_data);

endinterface

// File: rob.sv
module rob #(
    parameter int ways = 2
) (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [$clog2(ways+1)-1:0]        dispatch_count,    // Packets taken from slot 0 upward
    input  r10k_pkg::rob_packet_t [ways-1:0] dispatch_packets,
    output logic                             rob_space_ok,      // Room for a whole group
    retire_if.rob_side                       rob_port
);
    import r10k_pkg::*;

    localparam int ptr_w   = $clog2(rob_depth);
    localparam int occ_w   = ptr_w + 1;
    localparam int count_w = $clog2(ways + 1);
    localparam logic [occ_w-1:0] ways_wide = occ_w'(ways);

    rob_packet_t      entries [rob_depth];  // Validity comes from head and occupancy
    logic [ptr_w-1:0] head;                 // Oldest instruction
    logic [ptr_w-1:0] tail;                 // Next free slot
    logic [occ_w-1:0] occupancy;

    // The dispatcher sends only while the top level reports ready
    // Entries freed in this same cycle are not counted
    assign rob_space_ok = (occ_w'(rob_depth) - occupancy) >= ways_wide;

    always_comb begin
        for (int i = 0; i < ways; i++) begin
            rob_port.rob_outputs[i] = entries[head + ptr_w'(i)];  // Wraps at rob_depth
        end
        // Retire sees at most one group, fewer when the buffer is almost empty
        if (occupancy >= ways_wide) begin
            rob_port.rob_outputs_valid = count_w'(ways);
        end else begin
            rob_port.rob_outputs_valid = count_w'(occupancy);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            occupancy <= '0;
        end else begin
            head      <= head + ptr_w'(rob_port.num_retiring);
            tail      <= tail + ptr_w'(dispatch_count);
            // Push and pop may happen together
            occupancy <= occupancy + occ_w'(dispatch_count) - occ_w'(rob_port.num_retiring);
        end
    end

    // Slot i of the group lands i places after the tail
    always_ff @(posedge clock) begin
        for (int i = 0; i < ways; i++) begin
            if (i < dispatch_count) begin
                entries[tail + ptr_w'(i)] <= dispatch_packets[i];
            end
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_backend -f list.f \
    --Mdir obj_dir -o tb_backend_sim

sim_output=$(./obj_dir/tb_backend_sim)
echo "$sim_output"

if grep -qF '*** TEST PASSED ***' <<< "$sim_output"; then
    exit 0
else
    exit 1
fi

// File: tb_backend.sv
module tb_backend;
    import r10k_pkg::*;

    localparam int ways           = 2;
    localparam int count_w        = $clog2(ways + 1);
    localparam int total_insts    = 200;
    localparam int recycle_groups = 40;   // 80 registers, more than the 32 free after reset
    localparam int fill_limit     = 3000; // Cycles allowed for the first run to dispatch
    localparam int drain_limit    = 500;
    localparam int halt_limit     = 200;
    localparam int quiet_window   = 40;   // Longer than the largest writeback delay
    localparam int max_wb_delay   = 12;

    logic                      clock;
    logic                      reset;
    logic [count_w-1:0]        dispatch_count;
    addr_t [ways-1:0]          dispatch_npc;
    arch_reg_idx_t [ways-1:0]  dispatch_arch_dest;
    logic [ways-1:0]           dispatch_has_dest;
    logic [ways-1:0]           dispatch_halt;
    logic [ways-1:0]           dispatch_illegal;
    logic                      dispatch_ready;
    phys_reg_idx_t [ways-1:0]  dispatch_t_new;
    logic [ways-1:0]           wb_valid;
    phys_reg_idx_t [ways-1:0]  wb_phys_reg;
    data_t [ways-1:0]          wb_data;
    logic [ways-1:0]           committed_valid;
    addr_t [ways-1:0]          committed_npc;
    arch_reg_idx_t [ways-1:0]  committed_reg_idx;
    data_t [ways-1:0]          committed_data;
    logic [ways-1:0]           committed_halt;
    logic [ways-1:0]           committed_illegal;
    logic                      halted;
    logic                      ready_expected;
    int                        error_count;
    int                        commit_count;
    int                        outstanding;

    phys_reg_idx_t pending_reg [$];  // Registers still waiting for their writeback
    int            pending_due [$];  // Cycle from which each one may be written
    int            cycle = 0;
    int            dispatched = 0;
    int            timeout_count = 0;
    addr_t         next_npc = 32'h0000_1000;

    backend_top #(.ways(ways)) dut0 (.*);

    commit_checker #(.ways(ways)) checker0 (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Writes back due registers, the random delays make the order differ from dispatch
    task automatic drive_writebacks();
        int slot;
        int idx;
        wb_valid = '0;
        slot     = 0;
        idx      = 0;
        while (slot < ways && idx < pending_reg.size()) begin
            if (pending_due[idx] <= cycle) begin
                wb_valid[slot]    = 1'b1;
                wb_phys_reg[slot] = pending_reg[idx];
                wb_data[slot]     = $urandom;
                pending_reg.delete(idx);
                pending_due.delete(idx);
                slot++;
            end else begin
                idx++;
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge clock);
        cycle++;
        dispatch_count = '0;
        ready_expected = 1'b0;
        drive_writebacks();
    endtask

    task automatic dispatch_group(input int count, input logic [ways-1:0] halt_mask);
        dispatch_count = count_w'(count);
        for (int i = 0; i < ways; i++) begin
            dispatch_npc[i]       = next_npc;
            dispatch_arch_dest[i] = arch_reg_idx_t'($urandom_range(0, arch_reg_count - 1));
            dispatch_has_dest[i]  = ($urandom_range(0, 3) != 0);
            dispatch_illegal[i]   = ($urandom_range(0, 15) == 0);
            dispatch_halt[i]      = halt_mask[i];
            if (i < count) begin
                pending_reg.push_back(dispatch_t_new[i]);  // t_new depends only on the free list
                pending_due.push_back(cycle + int'($urandom_range(1, max_wb_delay)));
                next_npc = next_npc + 32'd4;
                dispatched++;
            end
        end
    endtask

    task automatic wait_drain(input string phase_name);
        int waited;
        waited = 0;
        while ((outstanding != 0 || pending_reg.size() != 0) && waited < drain_limit) begin
            next_cycle();
            waited++;
        end
        if (outstanding != 0 || pending_reg.size() != 0) begin
            $display("Timeout: the %s did not drain within %0d cycles", phase_name, drain_limit);
            timeout_count++;
        end
    endtask

    initial begin
        int               waited;
        int               n;
        logic [ways-1:0]  last_slot;
        void'($urandom(32'h5655));
        reset              = 1'b1;
        ready_expected     = 1'b0;
        dispatch_count     = '0;
        dispatch_npc       = '0;
        dispatch_arch_dest = '0;
        dispatch_has_dest  = '0;
        dispatch_halt      = '0;
        dispatch_illegal   = '0;
        wb_valid           = '0;
        wb_phys_reg        = '0;
        wb_data            = '0;
        repeat (16) @(negedge clock);
        reset = 1'b0;

        // Random groups of random size while the backend accepts them
        while (dispatched < total_insts && cycle < fill_limit) begin
            next_cycle();
            if (dispatch_ready && $urandom_range(0, 3) != 0) begin
                n = int'($urandom_range(1, ways));
                if (n > total_insts - dispatched) n = total_insts - dispatched;
                dispatch_group(n, '0);
            end
        end
        if (dispatched < total_insts) begin
            $display("Timeout: only %0d of %0d instructions were dispatched", dispatched,
                     total_insts);
            timeout_count++;
        end
        if (timeout_count == 0) wait_drain("first run");

        // Each full group must find room right after the previous one drained
        for (int g = 0; g < recycle_groups && timeout_count == 0; g++) begin
            next_cycle();
            ready_expected = 1'b1;
            if (dispatch_ready) dispatch_group(ways, '0);
            wait_drain("recycle run");
        end

        // Halt in the last slot, followed by one full group that must never commit
        if (timeout_count == 0) begin
            last_slot           = '0;
            last_slot[ways-1]   = 1'b1;
            next_cycle();
            if (dispatch_ready) dispatch_group(ways, last_slot);
            next_cycle();
            if (dispatch_ready) dispatch_group(ways, '0);
            waited = 0;
            while (!halted && waited < halt_limit) begin
                next_cycle();
                waited++;
            end
            if (!halted) begin
                $display("Timeout: halted did not rise within %0d cycles", halt_limit);
                timeout_count++;
            end
            repeat (quiet_window) next_cycle();  // Younger writebacks land inside this window
        end

        $display("Summary: %0d commits checked, %0d check errors, %0d timeouts",
                 commit_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
